// ==== hdl/rv_core_defs.svh ====
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Data path and address width of the integer core
`define XLEN 32

// Architectural integer registers including the hardwired x0
`define NUM_REGS 32

// Depth of the tightly coupled instruction memory in words
`define IMEM_WORDS 256

// Depth of the tightly coupled data memory in words
`define DMEM_WORDS 256

`endif

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    // Function codes shared by the register and immediate ALU forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    // Only SUB sets this funct7 among the supported R-type instructions
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // --------------------------------------------------
    // Instruction formats
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    // Branch offsets are scrambled so the sign bit stays at bit 31
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_fmt_t;

    // One fetched word seen through every format at once
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // Operations the ALU can perform
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT
    } alu_op_t;

endpackage

`default_nettype wire

// ==== hdl/rv_pipe_pkg.sv ====
`default_nettype none

`include "rv_core_defs.svh"

package rv_pipe_pkg;

    // Operand source picked by the hazard unit for each ALU input
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_t;

    // --------------------------------------------------
    // Pipeline registers
    // --------------------------------------------------
    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   instr;
    } ifid_t;

    // Unused source fields are kept at zero so they never match a hazard
    typedef struct packed {
        logic                 valid;
        logic [`XLEN-1:0]     pc;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic [`XLEN-1:0]     rs1_val;
        logic [`XLEN-1:0]     rs2_val;
        logic [`XLEN-1:0]     imm;
        rv_isa_pkg::alu_op_t  alu_op;
        logic                 use_imm;
        logic                 reg_wren;
        logic                 mem_ren;
        logic                 mem_wren;
        logic                 is_branch;
        logic                 branch_ne;
        logic                 is_jump;
    } idex_t;

    typedef struct packed {
        logic               valid;
        logic [4:0]         rd;
        logic [`XLEN-1:0]   alu_result;
        logic [`XLEN-1:0]   store_data;
        logic               reg_wren;
        logic               mem_ren;
        logic               mem_wren;
    } exmem_t;

    // Result already holds the load data or the ALU value
    typedef struct packed {
        logic               valid;
        logic [4:0]         rd;
        logic [`XLEN-1:0]   result;
        logic               reg_wren;
    } memwb_t;

endpackage

`default_nettype wire

// ==== hdl/hazard_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hazard_if;
    import rv_pipe_pkg::*;

    // Sources of the instruction sitting in decode
    logic [4:0] d_rs1;
    logic [4:0] d_rs2;

    // Instruction in execute and whether it redirects the PC
    logic [4:0] e_rs1;
    logic [4:0] e_rs2;
    logic [4:0] e_rd;
    logic       e_mem_ren;
    logic       e_redirect;

    // Destinations waiting in EX/MEM and MEM/WB
    logic [4:0] m_rd;
    logic       m_reg_wren;
    logic [4:0] w_rd;
    logic       w_reg_wren;

    // Controls returned by the hazard unit
    logic       stall_if;
    logic       ifid_wren;
    logic       ifid_flush;
    logic       idex_flush;
    fwd_sel_t   rs1_sel;
    fwd_sel_t   rs2_sel;

    modport fetch   (input stall_if);
    modport decode  (output d_rs1, d_rs2, input ifid_wren, ifid_flush, idex_flush);
    modport execute (output e_rs1, e_rs2, e_rd, e_mem_ren, e_redirect,
                     input rs1_sel, rs2_sel);
    modport memory  (output m_rd, m_reg_wren, w_rd, w_reg_wren);
    modport hazard  (input d_rs1, d_rs2, e_rs1, e_rs2, e_rd, e_mem_ren, e_redirect,
                     input m_rd, m_reg_wren, w_rd, w_reg_wren,
                     output stall_if, ifid_wren, ifid_flush, idex_flush, rs1_sel, rs2_sel);

endinterface

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module fetch_stage (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              imem_we,
    input  wire [$clog2(`IMEM_WORDS)-1:0]    imem_addr,
    input  wire [`XLEN-1:0]                  imem_wdata,
    input  wire                              redirect,
    input  wire [`XLEN-1:0]                  redirect_pc,
    hazard_if.fetch                          hz,
    output rv_pipe_pkg::ifid_t               ifid
);

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imem [`IMEM_WORDS];

    // --------------------------------------------------
    // Program counter
    // --------------------------------------------------
    // A redirect from execute wins over a hazard stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!hz.stall_if) begin
            pc <= pc + 'd4;
        end
    end

    // The loading port may write at any time, the core just reads the array
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // Word-addressed asynchronous read
    // Wrong-path words are squashed later by the IF/ID flush in decode
    assign ifid.valid = 1'b1;
    assign ifid.pc    = pc;
    assign ifid.instr = imem[pc[IMEM_AW+1:2]];

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module decode_stage (
    input  wire                  clk,
    input  wire                  reset,
    input  rv_pipe_pkg::ifid_t   ifid,
    input  rv_pipe_pkg::memwb_t  wb,
    hazard_if.decode             hz,
    output rv_pipe_pkg::idex_t   idex
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    ifid_t            ifid_q;
    instr_u           instr;
    idex_t            idex_d;
    logic             use_rs1;
    logic             use_rs2;
    logic             reg_write;
    alu_op_t          alu_dec;
    logic [`XLEN-1:0] rf [`NUM_REGS];

    // --------------------------------------------------
    // IF/ID register
    // --------------------------------------------------
    // Flush beats hold so a taken branch never keeps a wrong-path word
    always_ff @(posedge clk) begin
        if (reset || hz.ifid_flush) begin
            ifid_q <= '0;
        end else if (hz.ifid_wren) begin
            ifid_q <= ifid;
        end
    end

    assign instr = ifid_q.instr;

    // ALU operation from funct3, SUB only exists in the register form
    always_comb begin
        case (instr.r_fmt.funct3)
            F3_SLT:  alu_dec = SLT;
            F3_XOR:  alu_dec = XOR;
            F3_OR:   alu_dec = OR;
            F3_AND:  alu_dec = AND;
            F3_ADD_SUB: begin
                alu_dec = (instr.r_fmt.opcode == OP && instr.r_fmt.funct7 == F7_SUB)
                        ? SUB : ADD;
            end
            default: alu_dec = ADD;
        endcase
    end

    // --------------------------------------------------
    // Main decoder and immediate generation
    // --------------------------------------------------
    always_comb begin
        idex_d    = '0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        reg_write = 1'b0;
        idex_d.alu_op = ADD;
        case (instr.r_fmt.opcode)
            OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                reg_write = 1'b1;
                idex_d.alu_op = alu_dec;
            end
            OP_IMM: begin
                use_rs1 = 1'b1;
                reg_write = 1'b1;
                idex_d.use_imm = 1'b1;
                idex_d.alu_op = alu_dec;
                idex_d.imm = {{(`XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            LOAD: begin
                use_rs1 = 1'b1;
                reg_write = 1'b1;
                idex_d.use_imm = 1'b1;
                idex_d.mem_ren = 1'b1;
                idex_d.imm = {{(`XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            STORE: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                idex_d.use_imm = 1'b1;
                idex_d.mem_wren = 1'b1;
                idex_d.imm = {{(`XLEN-12){instr.s_fmt.imm_hi[6]}},
                              instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            end
            BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                idex_d.is_branch = (instr.b_fmt.funct3 == F3_BEQ) ||
                                   (instr.b_fmt.funct3 == F3_BNE);
                idex_d.branch_ne = (instr.b_fmt.funct3 == F3_BNE);
                idex_d.imm = {{(`XLEN-12){instr.b_fmt.imm12}}, instr.b_fmt.imm11,
                              instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
            end
            JAL: begin
                reg_write = 1'b1;
                idex_d.is_jump = 1'b1;
                idex_d.imm = {{(`XLEN-20){instr.j_fmt.imm20}}, instr.j_fmt.imm19_12,
                              instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
            end
            default: ;
        endcase
        idex_d.valid = ifid_q.valid;
        idex_d.pc    = ifid_q.pc;
        idex_d.rs1   = use_rs1 ? instr.r_fmt.rs1 : 5'd0;
        idex_d.rs2   = use_rs2 ? instr.r_fmt.rs2 : 5'd0;
        idex_d.rd    = instr.r_fmt.rd;
        // Writes to x0 are dropped here so nothing downstream sees them
        idex_d.reg_wren = reg_write && (instr.r_fmt.rd != 5'd0);
        // x0 reads as zero, the array entry is never written
        idex_d.rs1_val = (idex_d.rs1 == 5'd0) ? '0 : rf[idex_d.rs1];
        idex_d.rs2_val = (idex_d.rs2 == 5'd0) ? '0 : rf[idex_d.rs2];
    end

    assign hz.d_rs1 = idex_d.rs1;
    assign hz.d_rs2 = idex_d.rs2;

    // No write-through, the hazard unit stalls a same-cycle read instead
    always_ff @(posedge clk) begin
        if (wb.valid && wb.reg_wren && wb.rd != 5'd0) begin
            rf[wb.rd] <= wb.result;
        end
    end

    // ID/EX register, a bubble is an all-zero entry
    always_ff @(posedge clk) begin
        if (reset || hz.idex_flush || !ifid_q.valid) begin
            idex <= '0;
        end else begin
            idex <= idex_d;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module execute_stage (
    input  wire                  clk,
    input  wire                  reset,
    input  rv_pipe_pkg::idex_t   idex,
    input  wire [`XLEN-1:0]      mem_fwd,
    input  wire [`XLEN-1:0]      wb_fwd,
    hazard_if.execute            hz,
    output logic                 redirect,
    output logic [`XLEN-1:0]     redirect_pc,
    output rv_pipe_pkg::exmem_t  exmem
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] result;
    logic             operands_eq;
    logic             taken;

    // Picks the newest copy of a source register
    function automatic logic [`XLEN-1:0] fwd_mux(
        input fwd_sel_t         sel,
        input logic [`XLEN-1:0] reg_val,
        input logic [`XLEN-1:0] mem_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // --------------------------------------------------
    // Operand forwarding
    // --------------------------------------------------
    assign op_a    = fwd_mux(hz.rs1_sel, idex.rs1_val, mem_fwd, wb_fwd);
    assign rs2_fwd = fwd_mux(hz.rs2_sel, idex.rs2_val, mem_fwd, wb_fwd);
    // Stores keep rs2 as data and use the immediate for the address
    assign op_b    = idex.use_imm ? idex.imm : rs2_fwd;

    always_comb begin
        case (idex.alu_op)
            SUB:     alu_out = op_a - op_b;
            AND:     alu_out = op_a & op_b;
            OR:      alu_out = op_a | op_b;
            XOR:     alu_out = op_a ^ op_b;
            SLT:     alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_out = op_a + op_b;
        endcase
    end

    // JAL links the address after itself
    assign result = idex.is_jump ? idex.pc + 'd4 : alu_out;

    // --------------------------------------------------
    // Branch and jump resolution
    // --------------------------------------------------
    assign operands_eq = (op_a == rs2_fwd);
    assign taken       = idex.is_branch && (idex.branch_ne ? !operands_eq : operands_eq);
    assign redirect    = idex.valid && (taken || idex.is_jump);
    // Both branch and JAL targets are pc relative
    assign redirect_pc = idex.pc + idex.imm;

    assign hz.e_rs1      = idex.rs1;
    assign hz.e_rs2      = idex.rs2;
    assign hz.e_rd       = idex.rd;
    assign hz.e_mem_ren  = idex.mem_ren;
    assign hz.e_redirect = redirect;

    // EX/MEM register, bubbles from ID/EX arrive with every enable low
    always_ff @(posedge clk) begin
        if (reset) begin
            exmem <= '0;
        end else begin
            exmem.valid      <= idex.valid;
            exmem.rd         <= idex.rd;
            exmem.alu_result <= result;
            exmem.store_data <= rs2_fwd;
            exmem.reg_wren   <= idex.reg_wren;
            exmem.mem_ren    <= idex.mem_ren;
            exmem.mem_wren   <= idex.mem_wren;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module memory_stage (
    input  wire                  clk,
    input  wire                  reset,
    input  rv_pipe_pkg::exmem_t  exmem,
    hazard_if.memory             hz,
    output logic [`XLEN-1:0]     mem_fwd,
    output rv_pipe_pkg::memwb_t  wb
);

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [DMEM_AW-1:0] dmem_addr;
    logic [`XLEN-1:0]   dmem [`DMEM_WORDS];

    // Only whole words are supported so the low two address bits are dropped
    assign dmem_addr = exmem.alu_result[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (exmem.valid && exmem.mem_wren) begin
            dmem[dmem_addr] <= exmem.store_data;
        end
    end

    // --------------------------------------------------
    // MEM/WB register with the writeback select
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.valid    <= exmem.valid;
            wb.rd       <= exmem.rd;
            wb.result   <= exmem.mem_ren ? dmem[dmem_addr] : exmem.alu_result;
            wb.reg_wren <= exmem.reg_wren;
        end
    end

    // A load in this stage never feeds execute thanks to the load-use stall
    assign mem_fwd = exmem.alu_result;

    assign hz.m_rd       = exmem.rd;
    assign hz.m_reg_wren = exmem.reg_wren;
    assign hz.w_rd       = wb.rd;
    assign hz.w_reg_wren = wb.reg_wren;

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    hazard_if.hazard hz
);
    import rv_pipe_pkg::*;

    logic load_use;
    logic wb_decode;
    logic stall;

    // --------------------------------------------------
    // Stall detection
    // --------------------------------------------------
    // Load data only appears after MEM so the consumer must wait one cycle
    assign load_use = hz.e_mem_ren && (hz.e_rd != 5'd0) &&
                      ((hz.e_rd == hz.d_rs1) || (hz.e_rd == hz.d_rs2));

    // The register file is written at the end of this cycle and read now
    assign wb_decode = hz.w_reg_wren && (hz.w_rd != 5'd0) &&
                       ((hz.w_rd == hz.d_rs1) || (hz.w_rd == hz.d_rs2));

    // A redirect throws away the stalled instruction anyway
    assign stall = (load_use || wb_decode) && !hz.e_redirect;

    assign hz.stall_if   = stall;
    assign hz.ifid_wren  = !stall;
    assign hz.ifid_flush = hz.e_redirect;
    // Stall and redirect both leave a bubble in ID/EX
    assign hz.idex_flush = hz.e_redirect || stall;

    // --------------------------------------------------
    // Forwarding selection
    // --------------------------------------------------
    // MEM holds the younger result so it is checked first
    always_comb begin
        hz.rs1_sel = FWD_NONE;
        hz.rs2_sel = FWD_NONE;
        if (hz.m_reg_wren && hz.m_rd != 5'd0 && hz.m_rd == hz.e_rs1) begin
            hz.rs1_sel = FWD_MEM;
        end else if (hz.w_reg_wren && hz.w_rd != 5'd0 && hz.w_rd == hz.e_rs1) begin
            hz.rs1_sel = FWD_WB;
        end
        if (hz.m_reg_wren && hz.m_rd != 5'd0 && hz.m_rd == hz.e_rs2) begin
            hz.rs2_sel = FWD_MEM;
        end else if (hz.w_reg_wren && hz.w_rd != 5'd0 && hz.w_rd == hz.e_rs2) begin
            hz.rs2_sel = FWD_WB;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module rv_core_top (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              imem_we,
    input  wire [$clog2(`IMEM_WORDS)-1:0]    imem_addr,
    input  wire [`XLEN-1:0]                  imem_wdata,
    output logic                             retire_valid,
    output logic [4:0]                       retire_rd,
    output logic [`XLEN-1:0]                 retire_data
);
    import rv_pipe_pkg::*;

    ifid_t            ifid;
    idex_t            idex;
    exmem_t           exmem;
    memwb_t           wb;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;
    logic [`XLEN-1:0] mem_fwd;

    // Control traffic between the stages and the hazard unit
    hazard_if hz ();

    fetch_stage fetch_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .hz          (hz),
        .ifid        (ifid)
    );

    decode_stage decode_stage_inst (
        .clk   (clk),
        .reset (reset),
        .ifid  (ifid),
        .wb    (wb),
        .hz    (hz),
        .idex  (idex)
    );

    execute_stage execute_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .idex        (idex),
        .mem_fwd     (mem_fwd),
        .wb_fwd      (wb.result),
        .hz          (hz),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .exmem       (exmem)
    );

    memory_stage memory_stage_inst (
        .clk     (clk),
        .reset   (reset),
        .exmem   (exmem),
        .hz      (hz),
        .mem_fwd (mem_fwd),
        .wb      (wb)
    );

    hazard_unit hazard_unit_inst (
        .hz (hz)
    );

    // Every architectural register write is reported once as it retires
    assign retire_valid = wb.valid && wb.reg_wren && (wb.rd != 5'd0);
    assign retire_rd    = wb.rd;
    assign retire_data  = wb.result;

endmodule

`default_nettype wire

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_defs.svh"

module rv_core_tb;

    localparam int IMEM_AW        = $clog2(`IMEM_WORDS);
    localparam int PROG_WORDS     = 29;
    localparam int NUM_RETIRES    = 19;
    localparam int RESET_CYCLES   = 10;
    localparam int RETIRE_TIMEOUT = 50;
    localparam int QUIET_CYCLES   = 30;

    // RV32I encoding fields as the ISA defines them
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [2:0] F3_ADD     = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // --------------------------------------------------
    // Expected retires, {rd, data}, from RV32I semantics
    // --------------------------------------------------
    localparam logic [36:0] EXPECTED_RETIRES [NUM_RETIRES] = '{
        {5'd1,  32'h0000_0005},   // addi x1 = 5
        {5'd2,  32'h0000_000C},   // addi x2 = 12
        {5'd3,  32'h0000_0011},   // add x3 = 5 + 12
        {5'd4,  32'h0000_000C},   // sub x4 = 17 - 5
        {5'd5,  32'h0000_0001},   // slt 12 < 17
        {5'd6,  32'h0000_0000},   // slt 17 < 12 is false
        {5'd7,  32'hFFFF_FFFE},   // xori 1 ^ -1
        {5'd8,  32'h0000_00F0},   // andi with 0xF0
        {5'd9,  32'h0000_00FF},   // ori with 0x0F
        {5'd10, 32'h0000_00FE},   // and 0xFF & -2
        {5'd11, 32'h0000_00FE},   // or with zero
        {5'd12, 32'h0000_00FB},   // xor 0xFE ^ 5
        {5'd13, 32'h0000_0001},   // slt -2 < 5 signed
        {5'd14, 32'h0000_00FB},   // lw returns the stored word
        {5'd15, 32'h0000_0100},   // add right after the load
        {5'd16, 32'h0000_0100},   // add x0 + x15
        {5'd18, 32'h0000_0021},   // addi after the not-taken bne
        {5'd19, 32'h0000_0060},   // jal links pc + 4
        {5'd20, 32'h0000_0081}    // add link + 33
    };

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   imem_we;
    logic [IMEM_AW-1:0]     imem_addr;
    logic [`XLEN-1:0]       imem_wdata;
    logic                   retire_valid;
    logic [4:0]             retire_rd;
    logic [`XLEN-1:0]       retire_data;
    logic [31:0]            program_words [PROG_WORDS];

    rv_core_top rv_core_top_inst (
        .clk          (clk),
        .reset        (reset),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    // 8 ns clock period
    always #4 clk = ~clk;

    function automatic logic [31:0] r_type_word(input logic [6:0] funct7,
        input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
        input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [6:0] opcode,
        input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] rs1,
        input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] s_type_word(input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    // Branch offsets are byte offsets with bit 0 implied zero
    function automatic logic [31:0] b_type_word(input logic [2:0] funct3,
        input logic [4:0] rs1, input logic [4:0] rs2, input logic [12:0] offset);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type_word(input logic [4:0] rd, input logic [20:0] offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, OPC_JAL};
    endfunction

    // --------------------------------------------------
    // Program, one word per address from 0x00
    // --------------------------------------------------
    task automatic build_program();
        program_words[0]  = i_type_word(OPC_OP_IMM, F3_ADD, 5'd1, 5'd0, 12'd5);
        program_words[1]  = i_type_word(OPC_OP_IMM, F3_ADD, 5'd2, 5'd0, 12'd12);
        // One step back comes from MEM, two steps back from writeback
        program_words[2]  = r_type_word(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2);
        // x1 is three steps back here, so decode must wait for the register file
        program_words[3]  = r_type_word(F7_SUB, F3_ADD, 5'd4, 5'd3, 5'd1);
        program_words[4]  = r_type_word(F7_BASE, F3_SLT, 5'd5, 5'd4, 5'd3);
        program_words[5]  = r_type_word(F7_BASE, F3_SLT, 5'd6, 5'd3, 5'd4);
        program_words[6]  = i_type_word(OPC_OP_IMM, F3_XOR, 5'd7, 5'd5, 12'hFFF);
        program_words[7]  = i_type_word(OPC_OP_IMM, F3_AND, 5'd8, 5'd7, 12'h0F0);
        program_words[8]  = i_type_word(OPC_OP_IMM, F3_OR, 5'd9, 5'd8, 12'h00F);
        program_words[9]  = r_type_word(F7_BASE, F3_AND, 5'd10, 5'd9, 5'd7);
        program_words[10] = r_type_word(F7_BASE, F3_OR, 5'd11, 5'd10, 5'd6);
        program_words[11] = r_type_word(F7_BASE, F3_XOR, 5'd12, 5'd11, 5'd1);
        program_words[12] = r_type_word(F7_BASE, F3_SLT, 5'd13, 5'd7, 5'd1);
        // Store then load of the same word, then a use right after the load
        program_words[13] = s_type_word(5'd12, 5'd0, 12'd16);
        program_words[14] = i_type_word(OPC_LOAD, F3_WORD, 5'd14, 5'd0, 12'd16);
        program_words[15] = r_type_word(F7_BASE, F3_ADD, 5'd15, 5'd14, 5'd1);
        // A write to x0 is dropped and x0 still reads zero afterwards
        program_words[16] = i_type_word(OPC_OP_IMM, F3_ADD, 5'd0, 5'd0, 12'd77);
        program_words[17] = r_type_word(F7_BASE, F3_ADD, 5'd16, 5'd0, 5'd15);
        // Taken beq to 0x54 skips the two x17 writes
        program_words[18] = b_type_word(F3_BEQ, 5'd16, 5'd15, 13'd12);
        program_words[19] = i_type_word(OPC_OP_IMM, F3_ADD, 5'd17, 5'd0, 12'd1);
        program_words[20] = i_type_word(OPC_OP_IMM, F3_ADD, 5'd17, 5'd0, 12'd2);
        program_words[21] = b_type_word(F3_BNE, 5'd16, 5'd15, 13'd8);
        program_words[22] = i_type_word(OPC_OP_IMM, F3_ADD, 5'd18, 5'd0, 12'd33);
        // jal to 0x68 skips two more wrong-path words
        program_words[23] = j_type_word(5'd19, 21'd12);
        program_words[24] = i_type_word(OPC_OP_IMM, F3_ADD, 5'd17, 5'd0, 12'd3);
        program_words[25] = i_type_word(OPC_OP_IMM, F3_ADD, 5'd17, 5'd0, 12'd4);
        program_words[26] = r_type_word(F7_BASE, F3_ADD, 5'd20, 5'd19, 5'd18);
        // Self loop that never writes a register
        program_words[27] = j_type_word(5'd0, 21'd0);
        // Fetched behind the self loop on every pass and flushed each time
        program_words[28] = i_type_word(OPC_OP_IMM, F3_ADD, 5'd17, 5'd0, 12'd5);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Samples once per cycle, 1 ns after the edge, until a retire shows up
    task automatic wait_for_retire(input int row, output int cycles);
        cycles = 0;
        while (retire_valid !== 1'b1) begin
            if (cycles >= RETIRE_TIMEOUT) begin
                $display("No retire for expected row %0d within %0d cycles", row, RETIRE_TIMEOUT);
                $display("TB FAILED");
                $fatal(1, "retire timeout");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int          i;
        int          row;
        int          cycles;
        logic [36:0] entry;

        reset      = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        build_program();

        // Reset stays high while the program is written, then for 10 more cycles
        for (i = 0; i < PROG_WORDS; i++) begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_addr  = i[IMEM_AW-1:0];
            imem_wdata = program_words[i];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            check_value("retire_valid", 32'd0, {31'd0, retire_valid});
        end
        reset = 1'b0;

        for (row = 0; row < NUM_RETIRES; row++) begin
            entry = EXPECTED_RETIRES[row];
            wait_for_retire(row, cycles);
            // Instruction 0 enters IF/ID on the first edge and needs four edges
            if (row == 0) begin
                check_value("first_retire_latency", 32'd4, cycles);
            end
            check_value("retire_rd", {27'd0, entry[36:32]}, {27'd0, retire_rd});
            check_value("retire_data", entry[31:0], retire_data);
            @(posedge clk);
            #1;
        end

        // The self jump must keep the retire port silent
        for (i = 0; i < QUIET_CYCLES; i++) begin
            check_value("retire_valid", 32'd0, {31'd0, retire_valid});
            @(posedge clk);
            #1;
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core_top.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/hazard_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_unit.sv
hdl/rv_core_top.sv
tests/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the rv_core testbench with Verilator and runs it.
# The exit status is the simulator's, so a $fatal in the testbench fails the script.

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module rv_core_tb -f rv_core_top.f -o rv_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/rv_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
